/* fetch_settings.svh */
/* fetch stage constants
   reset pc, AXI read id and the width of one fetch window */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// byte address of the first instruction fetched after reset
`define FETCH_BOOT_PC 32'h0000_0000

// AXI read id width and the id placed on arid
`define FETCH_AXI_ID_WIDTH 4
`define FETCH_AXI_ID 2

// two 64-bit beats, four words
`define FETCH_WINDOW_BITS 128

`endif

/* fetch_pkg.sv */
/* fetch stage types
   pre-decode result and the packet handed to decode */
package fetch_pkg;

  // result of looking at one instruction before it leaves fetch
  typedef struct packed {
    logic        compressed;
    logic        jump;
    logic        br;
    logic        illegal;
    // halfword address of the direct jump target
    logic [31:1] target;
  } predecode_t;

  // one instruction on its way to decode
  typedef struct packed {
    // halfword address of the instruction
    logic [31:1] pc;
    // upper half is zero for compressed instructions
    logic [31:0] instr;
    logic        compressed;
    logic        br;
    logic        illegal;
  } fetch_pkt_t;

endpackage : fetch_pkg

/* fetch_mem_if.sv */
/* request and response channel between the fetch unit
   and its memory controller */
`timescale 1ns/100ps
`include "fetch_settings.svh"

interface fetch_mem_if;

  logic                          req_valid;
  logic                          req_ready;
  // halfword address, the controller aligns it to the bus
  logic [31:1]                   req_addr;
  logic                          flush;
  logic                          rsp_valid;
  logic                          rsp_ready;
  logic [`FETCH_WINDOW_BITS-1:0] rsp_window;

  modport ifu (
    output req_valid, req_addr, flush, rsp_ready,
    input  req_ready, rsp_valid, rsp_window
  );

  modport ctrl (
    input  req_valid, req_addr, flush, rsp_ready,
    output req_ready, rsp_valid, rsp_window
  );

endinterface : fetch_mem_if

/* instr_predecoder.sv */
/* instruction pre-decoder
   finds compressed, direct jump, branch and illegal encodings and the jump target */
`timescale 1ns/100ps

module instr_predecoder (
  input  logic [31:0]           instr,
  input  logic [31:1]           pc,
  output fetch_pkg::predecode_t pd
);

  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;

  logic        compressed;
  logic        quad1;
  logic [2:0]  c_funct3;
  logic        c_jump;
  logic        c_br;
  logic [31:0] j_imm;
  logic [31:0] cj_imm;
  logic [31:0] imm;

  assign compressed = (instr[1:0] != 2'b11);
  assign quad1      = (instr[1:0] == 2'b01);
  assign c_funct3   = instr[15:13];

  // C.J and C.JAL (RV32 only)
  assign c_jump = quad1 && (c_funct3 == 3'b101 || c_funct3 == 3'b001);
  // C.BEQZ and C.BNEZ
  assign c_br   = quad1 && (c_funct3 == 3'b110 || c_funct3 == 3'b111);

  // J-type immediate, imm[20|10:1|11|19:12]
  assign j_imm = {
    {12{instr[31]}},
    instr[19:12],
    instr[20],
    instr[30:21],
    1'b0
  };

  // CJ-type immediate, offset[11|4|9:8|10|6|7|3:1|5]
  assign cj_imm = {
    {21{instr[12]}},
    instr[8],
    instr[10:9],
    instr[6],
    instr[7],
    instr[2],
    instr[11],
    instr[5:3],
    1'b0
  };

  assign imm = compressed ? cj_imm : j_imm;

  assign pd.compressed = compressed;
  assign pd.jump       = (instr[6:0] == op_jal) || c_jump;
  assign pd.br         = (instr[6:0] == op_branch) || c_br;
  // zero halfword and all-ones word are both defined illegal
  assign pd.illegal    = (instr[15:0] == 16'h0000) || (instr == 32'hffff_ffff);
  assign pd.target     = pc + imm[31:1];

endmodule : instr_predecoder

/* ifu_mem_ctrl.sv */
/* AXI4 read master for instruction fetch
   each request becomes a two-beat INCR burst returned as one 128-bit window */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module ifu_mem_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  fetch_mem_if.ctrl                      mem,

  output logic [`FETCH_AXI_ID_WIDTH-1:0] arid,
  output logic [31:0]                    araddr,
  output logic [7:0]                     arlen,
  output logic [2:0]                     arsize,
  output logic [1:0]                     arburst,
  output logic                           arlock,
  output logic [3:0]                     arcache,
  output logic [2:0]                     arprot,
  output logic [3:0]                     arqos,
  output logic [3:0]                     arregion,
  output logic                           arvalid,
  input  logic                           arready,

  input  logic [`FETCH_AXI_ID_WIDTH-1:0] rid,
  input  logic [63:0]                    rdata,
  input  logic [1:0]                     rresp,
  input  logic                           rlast,
  input  logic                           rvalid,
  output logic                           rready
);

  typedef enum logic [2:0] {
    s_idle,
    s_addr,
    s_data,
    s_hold,
    s_drain
  } state_t;

  state_t                        state;
  logic                          cancel;
  logic                          req_fire;
  logic                          r_beat;
  logic [`FETCH_WINDOW_BITS-1:0] window_q;

  assign req_fire = mem.req_valid && mem.req_ready;
  // only beats carrying our own id count
  assign r_beat   = rvalid && rready && (rid == `FETCH_AXI_ID_WIDTH'(`FETCH_AXI_ID));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= s_idle;
      cancel <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (req_fire) state <= s_addr;
        end
        s_addr: begin
          // the address handshake has to finish even when flushed
          if (arready) begin
            state  <= (cancel || mem.flush) ? s_drain : s_data;
            cancel <= 1'b0;
          end else if (mem.flush) begin
            cancel <= 1'b1;
          end
        end
        s_data: begin
          if (r_beat && rlast) state <= mem.flush ? s_idle : s_hold;
          else if (mem.flush) state <= s_drain;
        end
        s_hold: begin
          if (mem.flush || mem.rsp_ready) state <= s_idle;
        end
        s_drain: begin
          if (r_beat && rlast) state <= s_idle;
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) araddr <= {mem.req_addr[31:3], 3'b000};
  end

  // beat 0 fills the low half, the rlast beat the high half
  always_ff @(posedge clk) begin
    if (state == s_data && r_beat) begin
      if (rlast) window_q[`FETCH_WINDOW_BITS-1:64] <= rdata;
      else window_q[63:0] <= rdata;
    end
  end

  assign arid     = `FETCH_AXI_ID_WIDTH'(`FETCH_AXI_ID);
  assign arlen    = 8'd1;
  assign arsize   = 3'd3;
  assign arburst  = 2'b01;
  assign arlock   = 1'b0;
  assign arcache  = 4'b0000;
  assign arprot   = 3'b000;
  assign arqos    = 4'b0000;
  assign arregion = 4'b0000;
  assign arvalid  = (state == s_addr);
  assign rready   = (state == s_data) || (state == s_drain);

  assign mem.req_ready  = (state == s_idle);
  assign mem.rsp_valid  = (state == s_hold);
  assign mem.rsp_window = window_q;

endmodule : ifu_mem_ctrl

/* ifu.sv */
/* instruction fetch unit
   owns the pc, picks the instruction out of each window and registers it for decode */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module ifu (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:1]           pc_in,
  input  logic                  pc_update,
  fetch_mem_if.ifu              mem,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fetch_pkg::fetch_pkt_t out_pkt
);

  import fetch_pkg::*;

  localparam logic [31:0] boot_pc = `FETCH_BOOT_PC;

  logic [31:1] pc;
  logic [31:1] next_pc;
  logic        req_valid;
  logic        flush_q;
  logic        rsp_fire;
  logic [31:0] instr;
  predecode_t  pd;

  // the window starts on an 8-byte boundary, pc[2:1] is the halfword offset
  assign instr = mem.rsp_window[{pc[2:1], 4'b0000} +: 32];

  instr_predecoder u_predec (
    .instr (instr),
    .pc    (pc),
    .pd    (pd)
  );

  // no response is taken while a redirect is being applied
  assign mem.rsp_ready = (!out_valid || out_ready) && !pc_update && !flush_q;
  assign rsp_fire      = mem.rsp_valid && mem.rsp_ready;

  always_comb begin
    if (pc_update) next_pc = pc_in;
    else if (pd.jump) next_pc = pd.target;
    else next_pc = pc + (pd.compressed ? 31'd1 : 31'd2);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pc <= boot_pc[31:1];
    else if (pc_update || rsp_fire) pc <= next_pc;
  end

  // reset acts like a redirect to the boot pc
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) flush_q <= 1'b1;
    else flush_q <= pc_update;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else begin
      if (pc_update) req_valid <= 1'b0;
      else if (flush_q) req_valid <= 1'b1;
      else if (rsp_fire) req_valid <= 1'b1;
      else if (mem.req_ready) req_valid <= 1'b0;
    end
  end

  assign mem.req_valid = req_valid;
  assign mem.req_addr  = pc;
  assign mem.flush     = flush_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      if (pc_update) out_valid <= 1'b0;
      else if (rsp_fire) out_valid <= 1'b1;
      else if (out_ready) out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_fire) begin
      out_pkt.pc         <= pc;
      out_pkt.instr      <= pd.compressed ? {16'h0000, instr[15:0]} : instr;
      out_pkt.compressed <= pd.compressed;
      out_pkt.br         <= pd.br;
      out_pkt.illegal    <= pd.illegal;
    end
  end

endmodule : ifu

/* fetch_top.sv */
/* instruction fetch stage top level
   fetch unit plus AXI read master, with plain bus and decode ports */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [31:1]                    pc_in,
  input  logic                           pc_update,

  output logic [`FETCH_AXI_ID_WIDTH-1:0] arid,
  output logic [31:0]                    araddr,
  output logic [7:0]                     arlen,
  output logic [2:0]                     arsize,
  output logic [1:0]                     arburst,
  output logic                           arlock,
  output logic [3:0]                     arcache,
  output logic [2:0]                     arprot,
  output logic [3:0]                     arqos,
  output logic [3:0]                     arregion,
  output logic                           arvalid,
  input  logic                           arready,

  input  logic [`FETCH_AXI_ID_WIDTH-1:0] rid,
  input  logic [63:0]                    rdata,
  input  logic [1:0]                     rresp,
  input  logic                           rlast,
  input  logic                           rvalid,
  output logic                           rready,

  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [31:1]                    out_pc,
  output logic [31:0]                    out_instr,
  output logic                           out_compressed,
  output logic                           out_br,
  output logic                           out_illegal
);

  import fetch_pkg::*;

  fetch_pkt_t out_pkt;

  fetch_mem_if mem_if ();

  ifu u_ifu (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_in     (pc_in),
    .pc_update (pc_update),
    .mem       (mem_if.ifu),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pkt   (out_pkt)
  );

  ifu_mem_ctrl u_mem_ctrl (
    .clk, .rst_n,
    .mem (mem_if.ctrl),
    .arid, .araddr, .arlen, .arsize, .arburst, .arlock,
    .arcache, .arprot, .arqos, .arregion, .arvalid, .arready,
    .rid, .rdata, .rresp, .rlast, .rvalid, .rready
  );

  assign out_pc         = out_pkt.pc;
  assign out_instr      = out_pkt.instr;
  assign out_compressed = out_pkt.compressed;
  assign out_br         = out_pkt.br;
  assign out_illegal    = out_pkt.illegal;

endmodule : fetch_top

/* axi_rom_model.sv */
/* AXI4 read-only memory model for the fetch testbench
   512 bytes of halfwords, random arready and rvalid delays, one burst at a time */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module axi_rom_model (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [31:0]                    araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [`FETCH_AXI_ID_WIDTH-1:0] rid,
  output logic [63:0]                    rdata,
  output logic [1:0]                     rresp,
  output logic                           rlast,
  output logic                           rvalid,
  input  logic                           rready
);

  logic [15:0] mem [0:255];
  logic        ar_hs;
  logic        r_hs;
  logic [31:0] addr_q;
  logic        busy;
  logic        beat;
  logic [7:0]  base;
  int          ar_wait;
  int          r_wait;

  assign rid   = `FETCH_AXI_ID_WIDTH'(`FETCH_AXI_ID);
  assign rresp = 2'b00;

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
    rdata   = 64'h0;
  end

  // handshakes happen on the rising edge
  always @(posedge clk) begin
    ar_hs <= arvalid && arready;
    r_hs  <= rvalid && rready;
    if (arvalid && arready) addr_q <= araddr;
  end

  // outputs change on the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rlast   = 1'b0;
      busy    = 1'b0;
      beat    = 1'b0;
      ar_wait = 0;
      r_wait  = 0;
    end else begin
      if (ar_hs) begin
        busy    = 1'b1;
        beat    = 1'b0;
        arready = 1'b0;
        r_wait  = $urandom % 4;
        ar_wait = $urandom % 4;
      end
      if (r_hs) begin
        if (rlast) busy = 1'b0;
        beat   = 1'b1;
        rvalid = 1'b0;
        rlast  = 1'b0;
        r_wait = $urandom % 4;
      end
      if (!busy) begin
        if (ar_wait > 0) ar_wait = ar_wait - 1;
        else arready = 1'b1;
      end else if (!rvalid) begin
        if (r_wait > 0) begin
          r_wait = r_wait - 1;
        end else begin
          base   = addr_q[8:1] + (beat ? 8'd4 : 8'd0);
          rdata  = {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
          rlast  = beat;
          rvalid = 1'b1;
        end
      end
    end
  end

endmodule : axi_rom_model

/* fetch_tb.sv */
/* fetch stage testbench
   runs a mixed program from an AXI ROM and checks every packet handed to decode */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_tb;

  typedef struct packed {
    logic        redirect;
    logic        held;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        compressed;
    logic        br;
    logic        illegal;
  } row_t;

  logic                           clk;
  logic                           rst_n;
  logic [31:1]                    pc_in;
  logic                           pc_update;
  logic [`FETCH_AXI_ID_WIDTH-1:0] arid;
  logic [31:0]                    araddr;
  logic [7:0]                     arlen;
  logic [2:0]                     arsize;
  logic [1:0]                     arburst;
  logic                           arlock;
  logic [3:0]                     arcache;
  logic [2:0]                     arprot;
  logic [3:0]                     arqos;
  logic [3:0]                     arregion;
  logic                           arvalid;
  logic                           arready;
  logic [`FETCH_AXI_ID_WIDTH-1:0] rid;
  logic [63:0]                    rdata;
  logic [1:0]                     rresp;
  logic                           rlast;
  logic                           rvalid;
  logic                           rready;
  logic                           out_valid;
  logic                           out_ready;
  logic [31:1]                    out_pc;
  logic [31:0]                    out_instr;
  logic                           out_compressed;
  logic                           out_br;
  logic                           out_illegal;

  row_t        rows[$];
  int          cycles = 0;
  int          limit = 0;
  int          seed;
  logic        held_valid;
  logic [31:1] held_pc;
  logic [31:0] held_instr;
  logic [2:0]  held_flags;

  fetch_top uut (.*);

  axi_rom_model rom (
    .clk, .rst_n, .araddr, .arvalid, .arready,
    .rid, .rdata, .rresp, .rlast, .rvalid, .rready
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: no progress after %0d cycles", cycles);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  // every burst is two 64-bit INCR beats from an aligned address
  always @(negedge clk) begin
    if (rst_n && arvalid) begin
      compare("arid", 32'(arid), 32'(`FETCH_AXI_ID));
      compare("araddr alignment", {29'b0, araddr[2:0]}, 32'd0);
      compare("arlen", {24'b0, arlen}, 32'd1);
      compare("arsize", {29'b0, arsize}, 32'd3);
      compare("arburst", {30'b0, arburst}, 32'd1);
      compare("ar side fields", {16'b0, arlock, arcache, arprot, arqos, arregion}, 32'd0);
    end
  end

  // JAL x0 with a 21-bit byte offset
  function automatic logic [31:0] jal_word(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
  endfunction

  // quadrant 1 jump format, C.J or C.JAL by funct3
  function automatic logic [15:0] cj_half(input logic [2:0] f3, input logic [11:0] off);
    return {f3, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5], 2'b01};
  endfunction

  task automatic put_half(input logic [31:0] addr, input logic [15:0] h);
    rom.mem[addr[8:1]] = h;
  endtask

  task automatic put_word(input logic [31:0] addr, input logic [31:0] w);
    put_half(addr, w[15:0]);
    put_half(addr + 32'd2, w[31:16]);
  endtask

  task automatic add_pkt(input logic [31:0] pc, input logic [31:0] instr,
                         input logic c, input logic br, input logic il);
    row_t r;
    r.redirect   = 1'b0;
    r.held       = 1'b0;
    r.pc         = pc;
    r.instr      = instr;
    r.compressed = c;
    r.br         = br;
    r.illegal    = il;
    rows.push_back(r);
  endtask

  task automatic add_redirect(input logic [31:0] pc, input logic held);
    row_t r;
    r = '0;
    r.redirect = 1'b1;
    r.held     = held;
    r.pc       = pc;
    rows.push_back(r);
  endtask

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic note_held();
    held_valid = out_valid;
    held_pc    = out_pc;
    held_instr = out_instr;
    held_flags = {out_compressed, out_br, out_illegal};
  endtask

  // a packet not taken by decode must stay put
  task automatic check_held();
    if (held_valid) begin
      compare("held out_valid", {31'b0, out_valid}, 32'd1);
      compare("held out_pc", {out_pc, 1'b0}, {held_pc, 1'b0});
      compare("held out_instr", out_instr, held_instr);
      compare("held flags", {29'b0, out_compressed, out_br, out_illegal}, {29'b0, held_flags});
    end
  endtask

  task automatic expect_packet(input row_t r);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      check_held();
      out_ready = ($urandom % 4) != 0;
      if (out_valid && out_ready) begin
        compare("out_pc", {out_pc, 1'b0}, r.pc);
        compare("out_instr", out_instr, r.instr);
        compare("out_compressed", {31'b0, out_compressed}, {31'b0, r.compressed});
        compare("out_br", {31'b0, out_br}, {31'b0, r.br});
        compare("out_illegal", {31'b0, out_illegal}, {31'b0, r.illegal});
        held_valid = 1'b0;
        done = 1'b1;
      end else begin
        note_held();
      end
    end
  endtask

  task automatic apply_redirect(input row_t r);
    if (r.held) begin
      // wait for a packet to sit at decode, then throw it away
      do begin
        @(negedge clk);
        check_held();
        out_ready = 1'b0;
        note_held();
      end while (!out_valid);
    end else begin
      // wait for a burst on the bus, a packet may sit at decode as well
      do begin
        @(negedge clk);
        check_held();
        out_ready = 1'b0;
        note_held();
      end while (!arvalid && !rready);
    end
    held_valid = 1'b0;
    pc_update  = 1'b1;
    pc_in      = r.pc[31:1];
    @(negedge clk);
    pc_update = 1'b0;
  endtask

  initial begin
    seed = $urandom(32'h583c);
    rst_n      = 1'b0;
    pc_in      = '0;
    pc_update  = 1'b0;
    out_ready  = 1'b0;
    held_valid = 1'b0;

    for (int i = 0; i < 256; i++) begin
      rom.mem[i] = {i[7:0], 8'h01};
    end
    put_half(32'h00, 16'h0001);
    put_word(32'h02, 32'h0010_0093);
    put_word(32'h06, 32'h0020_0113);
    put_half(32'h0a, 16'h4501);
    put_word(32'h0c, 32'h0000_0463);
    put_half(32'h10, 16'hc001);
    put_half(32'h12, 16'he001);
    put_word(32'h14, jal_word(21'h02c));
    put_half(32'h18, 16'h0001);
    put_word(32'h1a, 32'h0030_0193);
    put_word(32'h1e, jal_word(21'(-28)));
    put_half(32'h40, 16'h0001);
    put_half(32'h42, cj_half(3'b001, 12'h01e));
    put_half(32'h60, 16'h0000);
    put_word(32'h62, 32'hffff_ffff);
    put_half(32'h66, cj_half(3'b101, 12'(-78)));

    add_pkt(32'h00, 32'h0000_0001, 1'b1, 1'b0, 1'b0);
    add_pkt(32'h02, 32'h0010_0093, 1'b0, 1'b0, 1'b0);
    add_pkt(32'h06, 32'h0020_0113, 1'b0, 1'b0, 1'b0);
    add_pkt(32'h0a, 32'h0000_4501, 1'b1, 1'b0, 1'b0);
    add_pkt(32'h0c, 32'h0000_0463, 1'b0, 1'b1, 1'b0);
    add_pkt(32'h10, 32'h0000_c001, 1'b1, 1'b1, 1'b0);
    add_pkt(32'h12, 32'h0000_e001, 1'b1, 1'b1, 1'b0);
    add_pkt(32'h14, jal_word(21'h02c), 1'b0, 1'b0, 1'b0);
    add_pkt(32'h40, 32'h0000_0001, 1'b1, 1'b0, 1'b0);
    add_pkt(32'h42, {16'h0, cj_half(3'b001, 12'h01e)}, 1'b1, 1'b0, 1'b0);
    add_pkt(32'h60, 32'h0000_0000, 1'b1, 1'b0, 1'b1);
    add_pkt(32'h62, 32'hffff_ffff, 1'b0, 1'b0, 1'b1);
    add_pkt(32'h66, {16'h0, cj_half(3'b101, 12'(-78))}, 1'b1, 1'b0, 1'b0);
    add_pkt(32'h18, 32'h0000_0001, 1'b1, 1'b0, 1'b0);
    add_pkt(32'h1a, 32'h0030_0193, 1'b0, 1'b0, 1'b0);
    add_pkt(32'h1e, jal_word(21'(-28)), 1'b0, 1'b0, 1'b0);
    add_pkt(32'h02, 32'h0010_0093, 1'b0, 1'b0, 1'b0);
    add_redirect(32'h0c, 1'b0);
    add_pkt(32'h0c, 32'h0000_0463, 1'b0, 1'b1, 1'b0);
    add_pkt(32'h10, 32'h0000_c001, 1'b1, 1'b1, 1'b0);
    add_redirect(32'h40, 1'b1);
    add_pkt(32'h40, 32'h0000_0001, 1'b1, 1'b0, 1'b0);
    add_pkt(32'h42, {16'h0, cj_half(3'b001, 12'h01e)}, 1'b1, 1'b0, 1'b0);
    add_pkt(32'h60, 32'h0000_0000, 1'b1, 1'b0, 1'b1);
    add_redirect(32'h1a, 1'b0);
    add_pkt(32'h1a, 32'h0030_0193, 1'b0, 1'b0, 1'b0);
    add_pkt(32'h1e, jal_word(21'(-28)), 1'b0, 1'b0, 1'b0);
    add_pkt(32'h02, 32'h0010_0093, 1'b0, 1'b0, 1'b0);
    limit = rows.size() * 40 + 100;

    repeat (2) @(posedge clk);
    @(negedge clk);
    // no request and no packet while reset is held
    compare("out_valid in reset", {31'b0, out_valid}, 32'd0);
    compare("arvalid in reset", {31'b0, arvalid}, 32'd0);
    compare("rready in reset", {31'b0, rready}, 32'd0);
    rst_n = 1'b1;

    foreach (rows[i]) begin
      if (rows[i].redirect) apply_redirect(rows[i]);
      else expect_packet(rows[i]);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule : fetch_tb

/* project.f */
+incdir+.
fetch_pkg.sv
fetch_mem_if.sv
instr_predecoder.sv
ifu_mem_ctrl.sv
ifu.sv
fetch_top.sv
axi_rom_model.sv
fetch_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fetch stage testbench with Verilator
rm -f build.log sim.log
verilator --binary --timing -f project.f --top-module fetch_tb -o fetch_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
